/* src.f */
hw/snes_pkg.sv
hw/scan_ctrl_if.sv
hw/scan_timer.sv
hw/scan_fsm.sv
hw/button_shifter.sv
hw/apb_regs.sv
hw/snes_scanner.sv
tests/snes_pad_model.sv
tests/tb_snes_scanner.sv

/* Makefile */
# Verilator flow for the SNES pad scanner

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_snes_scanner
RTL_TOP   ?= snes_scanner
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN   := $(BUILD_DIR)/V$(TB_TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_snes_scanner.sv */
// SNES scanner testbench
`default_nettype none

module tb_snes_scanner import snes_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int GAP_TEST     = 20;                  // short gap for simulation
    localparam int N_ENTRIES    = 8;
    localparam int SCAN_CYC     = 34 * HALF_MIN + GAP_TEST + 50;
    localparam int WATCHDOG_CYC = (N_ENTRIES + 4) * SCAN_CYC + 200;
    localparam logic [7:0] ADDR_UNUSED = 8'h14;

    logic             clk;
    logic             resetn;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [7:0]       paddr;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    logic             joy_strb;
    logic             joy_clk;
    logic             joy_data;
    logic [BTN_W-1:0] pad_mask;                        // buttons held on the pad
    logic [BTN_W-1:0] mask_tab   [N_ENTRIES];          // stimulus
    logic [BTN_W-1:0] expect_tab [N_ENTRIES];          // expected BUTTONS value
    int               seed;
    int               strb_rises = 0;                  // latch pulses seen
    int               clk_falls  = 0;                  // joy_clk falls since last latch
    int               strb_width = 0;                  // cycles of current latch
    logic             prev_strb  = 1'b0;
    logic             prev_clk   = 1'b1;

    snes_scanner u_dut (
        .clk(clk), .resetn(resetn), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .joy_strb(joy_strb), .joy_clk(joy_clk), .joy_data(joy_data)
    );

    snes_pad_model u_pad (
        .joy_strb(joy_strb), .joy_clk(joy_clk), .mask(pad_mask), .joy_data(joy_data)
    );

    always #50 clk = ~clk;                             // 100 ns period

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_buttons(input string what, input logic [BTN_W-1:0] got,
                                 input logic [BTN_W-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    // setup phase, then access phase, write lands on the edge ending it
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);                                // prdata settled mid access phase
        data    = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] rd;
        apb_read(addr, rd);
        check_word(what, rd, exp);
    endtask

    // skip any latch that already fired, then wait for a fresh one
    task automatic wait_latch();
        int r;
        int cyc;
        @(negedge clk);
        #1;
        r   = strb_rises;
        cyc = 0;
        while (strb_rises == r) begin
            if (cyc == 2 * SCAN_CYC) fail_run("no latch pulse on joy_strb");
            else begin
                @(posedge clk);
                cyc++;
            end
        end
        #1;
    endtask

    task automatic wait_flag();
        logic [31:0] rd;
        int polls;
        rd    = '0;
        polls = 0;
        while (!rd[0]) begin
            if (polls == SCAN_CYC) fail_run("new-data flag never set");
            else begin
                apb_read(ADDR_STATUS, rd);
                polls++;
            end
        end
    endtask

    // latch width and clock pulse count, sampled away from the rising edge
    always @(negedge clk) begin
        if (joy_strb && !prev_strb) begin
            if (strb_rises > 0) check_count("joy_clk falls per scan", clk_falls, NUM_BITS);
            strb_rises++;
            clk_falls  = 0;
            strb_width = 1;
        end else if (joy_strb) begin
            strb_width++;
        end
        if (!joy_strb && prev_strb) check_count("latch width", strb_width, 2 * HALF_MIN);
        if (!joy_clk && prev_clk) clk_falls++;
        prev_strb = joy_strb;
        prev_clk  = joy_clk;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] rd;
        int          r;
        clk      = 1'b0;
        resetn   = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        pad_mask = '0;
        seed     = 32'h2fd6;
        mask_tab[0] = 16'h0000;                        // nothing pressed
        mask_tab[1] = 16'hFFFF;                        // all, top four never read
        mask_tab[2] = 16'h0001;                        // B alone
        mask_tab[3] = 16'h0800;                        // R alone
        mask_tab[4] = 16'h0010;                        // up alone
        for (int i = 5; i < N_ENTRIES; i++) mask_tab[i] = BTN_W'($random(seed));
        for (int i = 0; i < N_ENTRIES; i++) expect_tab[i] = mask_tab[i] & 16'h0FFF;

        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;

        check_bit("joy_strb after reset", joy_strb, 1'b0);
        check_bit("joy_clk after reset", joy_clk, 1'b1);
        read_expect(ADDR_CTRL, 32'h0, "CTRL after reset");
        read_expect(ADDR_HALF, 32'(HALF_DEFAULT), "HALF after reset");
        read_expect(ADDR_GAP, 32'(GAP_DEFAULT), "GAP after reset");
        read_expect(ADDR_BUTTONS, 32'h0, "BUTTONS after reset");
        read_expect(ADDR_STATUS, 32'h0, "STATUS after reset");

        apb_write(ADDR_HALF, 32'hFFFF_A5C3);           // upper bits dropped
        read_expect(ADDR_HALF, 32'h0000_A5C3, "HALF readback");
        apb_write(ADDR_GAP, 32'hFFF5_A5A5);
        read_expect(ADDR_GAP, 32'h0005_A5A5, "GAP readback");
        apb_write(ADDR_BUTTONS, 32'h0000_FFFF);        // read only
        read_expect(ADDR_BUTTONS, 32'h0, "BUTTONS after write");
        read_expect(ADDR_UNUSED, 32'h0, "unused address");
        apb_write(ADDR_HALF, 32'(HALF_MIN));
        apb_write(ADDR_GAP, 32'(GAP_TEST));
        read_expect(ADDR_HALF, 32'(HALF_MIN), "HALF short timing");
        read_expect(ADDR_GAP, 32'(GAP_TEST), "GAP short timing");
        apb_write(ADDR_CTRL, 32'h1);
        read_expect(ADDR_CTRL, 32'h1, "CTRL enable readback");

        for (int i = 0; i < N_ENTRIES; i++) begin
            pad_mask = mask_tab[i];
            wait_latch();                              // scan with the new mask
            apb_write(ADDR_STATUS, 32'h1);             // drop flag of older scan
            wait_flag();
            apb_read(ADDR_BUTTONS, rd);
            check_buttons($sformatf("BUTTONS entry %0d", i), rd[BTN_W-1:0], expect_tab[i]);
            read_expect(ADDR_STATUS, 32'h1, "STATUS set");
            apb_write(ADDR_STATUS, 32'h1);
            read_expect(ADDR_STATUS, 32'h0, "STATUS cleared");
        end

        // disable mid scan, that scan still finishes
        pad_mask = 16'h0C35;
        wait_latch();
        apb_write(ADDR_STATUS, 32'h1);
        apb_write(ADDR_CTRL, 32'h0);
        wait_flag();
        apb_read(ADDR_BUTTONS, rd);
        check_buttons("BUTTONS last scan", rd[BTN_W-1:0], 16'h0C35);
        read_expect(ADDR_CTRL, 32'h0, "CTRL disabled");
        r = strb_rises;
        repeat (2 * (34 * HALF_MIN + GAP_TEST + 10)) @(posedge clk);
        check_count("latch pulses after disable", strb_rises - r, 0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/snes_pad_model.sv */
// SNES pad behavioral model
`default_nettype none

module snes_pad_model import snes_pkg::*; (
    input  wire             joy_strb,
    input  wire             joy_clk,
    input  wire [BTN_W-1:0] mask,                      // pressed buttons, 1 = pressed
    output logic            joy_data
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [BTN_W-1:0] latched = '0;                    // mask captured by strobe
    logic [4:0]       pos     = 5'd16;                 // bit now on the data line

    // strobe rise reloads, each clock rise moves to the next button
    always @(posedge joy_strb or posedge joy_clk) begin
        if (joy_strb) begin
            latched <= mask;
            pos     <= 5'd0;                           // B comes out first
        end else if (pos != 5'd16) begin
            pos <= pos + 5'd1;                         // saturate after bit 16
        end
    end

    // active low, positions 13 to 16 and beyond read high
    always_comb begin
        if (pos < 5'd12) begin
            joy_data = ~latched[pos[3:0]];
        end else begin
            joy_data = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/snes_scanner.sv */
// SNES pad scanner top
`default_nettype none

module snes_scanner import snes_pkg::*; (
    input  wire         clk,
    input  wire         resetn,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        joy_strb,
    output logic        joy_clk,
    input  wire         joy_data
);

    logic              enable;                         // scan enable from CTRL
    logic [HALF_W-1:0] half_period;
    logic [GAP_W-1:0]  gap_len;
    logic [BTN_W-1:0]  buttons;                        // last complete scan
    logic              scan_done;                      // sets new-data flag

    scan_ctrl_if ctl_if ();                            // fsm, timer and shifter

    apb_regs u_regs (
        .clk         (clk),
        .resetn      (resetn),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .buttons     (buttons),
        .scan_done   (scan_done),
        .enable      (enable),
        .half_period (half_period),
        .gap_len     (gap_len)
    );

    scan_fsm u_fsm (
        .clk         (clk),
        .resetn      (resetn),
        .enable      (enable),
        .half_period (half_period),
        .gap_len     (gap_len),
        .joy_strb    (joy_strb),
        .joy_clk     (joy_clk),
        .ctl         (ctl_if.fsm)
    );

    scan_timer u_timer (
        .clk    (clk),
        .resetn (resetn),
        .tmr    (ctl_if.timer)
    );

    button_shifter u_shifter (
        .clk       (clk),
        .resetn    (resetn),
        .joy_data  (joy_data),
        .sh        (ctl_if.shifter),
        .buttons   (buttons),
        .scan_done (scan_done)
    );

endmodule

`default_nettype wire

/* hw/apb_regs.sv */
// APB register block
`default_nettype none

module apb_regs import snes_pkg::*; (
    input  wire               clk,
    input  wire               resetn,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire  [7:0]        paddr,
    input  wire  [31:0]       pwdata,
    output logic [31:0]       prdata,
    input  logic [BTN_W-1:0]  buttons,
    input  logic              scan_done,
    output logic              enable,
    output logic [HALF_W-1:0] half_period,
    output logic [GAP_W-1:0]  gap_len
);

    logic        wr_en;                                // write access phase
    logic        rd_en;                                // read access phase
    logic        new_flag;                             // sticky scan complete
    logic [31:0] rd_mux;

    assign wr_en = psel && penable && pwrite;
    assign rd_en = psel && penable && !pwrite;

    // control and timing registers, BUTTONS is read only
    always_ff @(posedge clk) begin
        if (!resetn) begin
            enable      <= 1'b0;
            half_period <= HALF_DEFAULT;
            gap_len     <= GAP_DEFAULT;
        end else if (wr_en) begin
            case (paddr)
                ADDR_CTRL: enable      <= pwdata[CTRL_ENABLE];
                ADDR_HALF: half_period <= pwdata[HALF_W-1:0];
                ADDR_GAP:  gap_len     <= pwdata[GAP_W-1:0];
                default:   ;                           // other writes dropped
            endcase
        end
    end

    // set wins over write-one-to-clear so no scan is missed
    always_ff @(posedge clk) begin
        if (!resetn) begin
            new_flag <= 1'b0;
        end else if (scan_done) begin
            new_flag <= 1'b1;
        end else if (wr_en && paddr == ADDR_STATUS && pwdata[0]) begin
            new_flag <= 1'b0;
        end
    end

    always_comb begin
        rd_mux = '0;                                   // unmapped reads give zero
        case (paddr)
            ADDR_CTRL:    rd_mux[CTRL_ENABLE]  = enable;
            ADDR_HALF:    rd_mux[HALF_W-1:0]   = half_period;
            ADDR_GAP:     rd_mux[GAP_W-1:0]    = gap_len;
            ADDR_BUTTONS: rd_mux[BTN_W-1:0]    = buttons;
            ADDR_STATUS:  rd_mux[0]            = new_flag;
            default:      rd_mux = '0;
        endcase
    end

    assign prdata = rd_en ? rd_mux : '0;               // zero outside access phase

    // access phase must follow a setup phase
    a_apb_setup: assert property (
        @(posedge clk) disable iff (!resetn)
        (psel && penable) |-> $past(psel && !penable)
    );

endmodule

`default_nettype wire

/* hw/button_shifter.sv */
// Pad data capture
`default_nettype none

module button_shifter import snes_pkg::*; (
    input  wire              clk,
    input  wire              resetn,
    input  wire              joy_data,
    scan_ctrl_if.shifter     sh,
    output logic [BTN_W-1:0] buttons,
    output logic             scan_done
);

    logic             data_meta;                       // first sync stage
    logic             data_sync;                       // safe to sample
    logic [BTN_W-1:0] shift_q;                         // bits collected so far

    // two-flop synchronizer on the async pad line
    always_ff @(posedge clk) begin
        data_meta <= joy_data;
        data_sync <= data_meta;
    end

    // pad sends B first, shifting in from the top puts it at bit 0
    always_ff @(posedge clk) begin
        if (sh.sample) begin
            shift_q <= {~data_sync, shift_q[BTN_W-1:1]};   // low means pressed
        end
    end

    // software sees only whole scans
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buttons <= '0;
        end else if (sh.scan_done) begin
            buttons <= shift_q;
        end
    end

    // flag sets on the same edge that updates buttons
    assign scan_done = sh.scan_done;

endmodule

`default_nettype wire

/* hw/scan_fsm.sv */
// Pad protocol state machine
`default_nettype none

module scan_fsm import snes_pkg::*; (
    input  wire              clk,
    input  wire              resetn,
    input  logic             enable,
    input  logic [HALF_W-1:0] half_period,
    input  logic [GAP_W-1:0] gap_len,
    output logic             joy_strb,
    output logic             joy_clk,
    scan_ctrl_if.fsm         ctl
);

    scan_state_t state;
    scan_state_t state_nxt;
    logic [3:0]  bit_cnt;                              // bit period within scan
    logic [GAP_W-1:0] half_lim;                        // H widened to timer width
    logic [GAP_W-1:0] latch_lim;                       // 2H for the strobe

    assign half_lim  = GAP_W'(half_period);
    assign latch_lim = GAP_W'({half_period, 1'b0});

    // next state and timer loads, each transition starts the next interval
    always_comb begin
        state_nxt       = state;
        ctl.timer_start = 1'b0;
        ctl.timer_limit = '0;
        ctl.sample      = 1'b0;
        ctl.scan_done   = 1'b0;
        case (state)
            IDLE: begin
                if (enable) begin
                    state_nxt       = LATCH;
                    ctl.timer_start = 1'b1;
                    ctl.timer_limit = latch_lim;
                end
            end
            LATCH: begin
                if (ctl.timer_expired) begin
                    state_nxt       = CLK_HIGH;
                    ctl.timer_start = 1'b1;
                    ctl.timer_limit = half_lim;
                end
            end
            CLK_HIGH: begin
                if (ctl.timer_expired) begin
                    state_nxt       = CLK_LOW;
                    ctl.timer_start = 1'b1;
                    ctl.timer_limit = half_lim;
                    ctl.sample      = 1'b1;            // joy_clk falls at this edge
                end
            end
            CLK_LOW: begin
                if (ctl.timer_expired) begin
                    ctl.timer_start = 1'b1;
                    if (bit_cnt == 4'(NUM_BITS - 1)) begin
                        state_nxt       = GAP;
                        ctl.timer_limit = gap_len;
                        ctl.scan_done   = 1'b1;
                    end else begin
                        state_nxt       = CLK_HIGH;
                        ctl.timer_limit = half_lim;
                    end
                end
            end
            GAP: begin
                if (ctl.timer_expired) begin
                    if (enable) begin                  // cleared enable stops here
                        state_nxt       = LATCH;
                        ctl.timer_start = 1'b1;
                        ctl.timer_limit = latch_lim;
                    end else begin
                        state_nxt = IDLE;
                    end
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // pad lines registered from the next state, so they follow state exactly
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= IDLE;
            joy_strb <= 1'b0;
            joy_clk  <= 1'b1;                          // pad clock idles high
            bit_cnt  <= '0;
        end else begin
            state    <= state_nxt;
            joy_strb <= (state_nxt == LATCH);
            joy_clk  <= (state_nxt != CLK_LOW);
            if (state == IDLE) begin
                bit_cnt <= '0;
            end else if (state == CLK_LOW && ctl.timer_expired) begin
                bit_cnt <= bit_cnt + 1'b1;             // wraps to 0 after bit 15
            end
        end
    end

    a_half_min: assert property (
        @(posedge clk) disable iff (!resetn)
        (state != IDLE) |-> (half_period >= HALF_W'(HALF_MIN))
    );

    a_strb_clk: assert property (
        @(posedge clk) disable iff (!resetn)
        !(joy_strb && !joy_clk)
    );

    a_sample_high: assert property (
        @(posedge clk) disable iff (!resetn)
        ctl.sample |-> (state == CLK_HIGH) && joy_clk
    );

endmodule

`default_nettype wire

/* hw/scan_timer.sv */
// Scan interval timer
`default_nettype none

module scan_timer import snes_pkg::*; (
    input  wire         clk,
    input  wire         resetn,
    scan_ctrl_if.timer  tmr
);

    logic [GAP_W-1:0] count;                           // cycles left in interval

    // down-counter, sits at zero when no interval is running
    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (tmr.timer_start) begin
            count <= tmr.timer_limit;                  // restart, even mid-interval
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // a limit of N loaded at cycle t gives count==1 at cycle t+N
    assign tmr.timer_expired = (count == GAP_W'(1));

    // zero limit would never expire and hang the fsm
    a_limit_nonzero: assert property (
        @(posedge clk) disable iff (!resetn)
        tmr.timer_start |-> (tmr.timer_limit != '0)
    );

endmodule

`default_nettype wire

/* hw/scan_ctrl_if.sv */
// Scan control interface
`default_nettype none

interface scan_ctrl_if import snes_pkg::*; ();

    logic             timer_start;                     // load timer, from fsm
    logic [GAP_W-1:0] timer_limit;                     // interval length in cycles
    logic             timer_expired;                   // last cycle of interval
    logic             sample;                          // falling edge of joy_clk
    logic             scan_done;                       // sixteenth bit finished

    modport fsm (
        output timer_start,
        output timer_limit,
        input  timer_expired,
        output sample,
        output scan_done
    );

    modport timer (
        input  timer_start,
        input  timer_limit,
        output timer_expired
    );

    modport shifter (
        input sample,
        input scan_done
    );

endinterface

`default_nettype wire

/* hw/snes_pkg.sv */
// SNES pad scanner definitions
`default_nettype none

package snes_pkg;

    // register field widths
    localparam int HALF_W   = 16;                      // half-period register
    localparam int GAP_W    = 20;                      // gap register, also timer width
    localparam int BTN_W    = 16;                      // button word
    localparam int NUM_BITS = 16;                      // clock pulses per scan

    // reset timing, tuned for a 21.5 MHz system clock
    localparam logic [HALF_W-1:0] HALF_DEFAULT = 16'd129;     // 6 us
    localparam logic [GAP_W-1:0]  GAP_DEFAULT  = 20'd344000;  // 16 ms

    // below this the synchronizer may not have settled at sample time
    localparam int HALF_MIN = 4;

    // register map
    localparam logic [7:0] ADDR_CTRL    = 8'h00;
    localparam logic [7:0] ADDR_HALF    = 8'h04;
    localparam logic [7:0] ADDR_GAP     = 8'h08;
    localparam logic [7:0] ADDR_BUTTONS = 8'h0C;
    localparam logic [7:0] ADDR_STATUS  = 8'h10;

    localparam int CTRL_ENABLE = 0;                    // scan enable bit in CTRL

    // scan protocol states
    typedef enum logic [2:0] {
        IDLE,                                          // not scanning
        LATCH,                                         // strobe high, 2H
        CLK_HIGH,                                      // clock high half
        CLK_LOW,                                       // clock low half
        GAP                                            // wait before next scan
    } scan_state_t;

endpackage

`default_nettype wire
